// File: buffer_pkg.sv
package buffer_pkg;

	// ------------------------------
	// host pipe word
	// ------------------------------
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] host_word_t;

	// ------------------------------
	// buffer sizing
	// ------------------------------
	localparam int DEFAULT_DEPTH      = 1023;  // full 1024 words not usable on the vendor fifo
	localparam int DEFAULT_BLOCK_SIZE = 128;   // 512 byte block, 4 bytes per word
	localparam int DEFAULT_HEADROOM   = 20;    // slack for count update latency

	// bits needed to hold an occupancy of 0 up to depth
	function automatic int count_w(input int depth);
		int w;
		w = 1;
		while ((1 << w) <= depth) begin
			w = w + 1;
		end
		return w;
	endfunction

endpackage

// File: host_ctrl_pkg.sv
package host_ctrl_pkg;

	// ------------------------------
	// control word bits
	// ------------------------------
	localparam int CTRL_PIPE_READ  = 0;
	localparam int CTRL_PIPE_WRITE = 1;  // enables the port 0 mover
	localparam int CTRL_FIFO_RESET = 2;  // flushes both pipe buffers
	localparam int CTRL_OP_EN      = 4;  // engine op request, only shown on the led

	// ------------------------------
	// status led order
	// ------------------------------
	localparam int LED_W = 6;

	localparam int LED_PI_FULL  = 5;
	localparam int LED_PI_EMPTY = 4;
	localparam int LED_PO_FULL  = 3;
	localparam int LED_PO_EMPTY = 2;
	localparam int LED_WRITE_EN = 1;
	localparam int LED_READ_EN  = 0;

endpackage

// File: pipe_in_buffer.sv
`timescale 1ns/10ps

module pipe_in_buffer #(
	parameter int DEPTH      = buffer_pkg::DEFAULT_DEPTH,
	parameter int BLOCK_SIZE = buffer_pkg::DEFAULT_BLOCK_SIZE,
	parameter int HEADROOM   = buffer_pkg::DEFAULT_HEADROOM
) (
	input  logic                   okClk,
	input  logic                   reset,
	input  logic                   flush,
	input  logic                   write,
	input  buffer_pkg::host_word_t data,
	input  logic                   pop,
	output buffer_pkg::host_word_t pop_data,
	output logic                   pop_valid,
	output logic                   empty,
	output logic                   full,
	output logic                   ready
);

	localparam int CW = buffer_pkg::count_w(DEPTH);
	localparam int PW = $clog2(DEPTH);
	// room for one more block, less the latency slack
	localparam logic [CW-1:0] THRESH = CW'(DEPTH - HEADROOM - BLOCK_SIZE);

	buffer_pkg::host_word_t mem [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_write;
	logic          do_pop;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		if (ptr == PW'(DEPTH - 1)) begin
			return '0;  // depth need not be a power of two
		end
		return ptr + 1'b1;
	endfunction

	assign empty    = (count == '0);
	assign full     = (count == CW'(DEPTH));
	assign do_write = write && !full;  // writes to a full buffer are dropped
	assign do_pop   = pop && !empty;

	// storage and registered read port
	always_ff @(posedge okClk) begin
		if (do_write) begin
			mem[wr_ptr] <= data;
		end
		if (do_pop) begin
			pop_data <= mem[rd_ptr];
		end
	end

	// ------------------------------
	// pointers, count, throttle
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (reset || flush) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
			ready     <= 1'b1;
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_write, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			pop_valid <= do_pop;
			ready     <= (count <= THRESH);  // follows the count one cycle late
		end
	end

endmodule

// File: pipe_out_buffer.sv
`timescale 1ns/10ps

module pipe_out_buffer #(
	parameter int DEPTH      = buffer_pkg::DEFAULT_DEPTH,
	parameter int BLOCK_SIZE = buffer_pkg::DEFAULT_BLOCK_SIZE
) (
	input  logic                                     okClk,
	input  logic                                     reset,
	input  logic                                     flush,
	input  logic                                     push,
	input  buffer_pkg::host_word_t                   push_data,
	input  logic                                     read,
	output buffer_pkg::host_word_t                   read_data,
	output logic                                     read_valid,
	output logic [buffer_pkg::count_w(DEPTH)-1:0]    count,
	output logic                                     empty,
	output logic                                     full,
	output logic                                     ready
);

	localparam int CW = buffer_pkg::count_w(DEPTH);
	localparam int PW = $clog2(DEPTH);

	buffer_pkg::host_word_t mem [DEPTH];

	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic          do_push;
	logic          do_read;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		if (ptr == PW'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == CW'(DEPTH));
	assign do_push = push && !full;  // mover must keep its own margin
	assign do_read = read && !empty;  // empty read gives no valid

	always_ff @(posedge okClk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
		if (do_read) begin
			read_data <= mem[rd_ptr];
		end
	end

	// ------------------------------
	// pointers, count, block flag
	// ------------------------------
	always_ff @(posedge okClk) begin
		if (reset || flush) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			read_valid <= 1'b0;
			ready      <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			read_valid <= do_read;
			ready      <= (count >= CW'(BLOCK_SIZE));  // a whole block is waiting
		end
	end

endmodule

// File: port0_mover.sv
`timescale 1ns/10ps

module port0_mover #(
	parameter int DEPTH = buffer_pkg::DEFAULT_DEPTH
) (
	input  logic                                  okClk,
	input  logic                                  reset,
	input  logic                                  enable,
	input  logic                                  eng_writes_en,
	input  buffer_pkg::host_word_t                eng_data,
	input  logic                                  eng_valid,
	input  logic                                  in_empty,
	input  buffer_pkg::host_word_t                in_data,
	input  logic                                  in_valid,
	output logic                                  in_pop,
	input  logic [buffer_pkg::count_w(DEPTH)-1:0] out_count,
	output logic                                  out_push,
	output buffer_pkg::host_word_t                out_data
);

	localparam int CW = buffer_pkg::count_w(DEPTH);
	localparam int SW = CW + 1;  // room for count plus in-flight words

	logic [1:0]             in_flight;  // pops not yet returned
	buffer_pkg::host_word_t eng_q;
	logic                   eng_q_valid;
	logic [SW-1:0]          committed;
	logic                   has_room;

	// ------------------------------
	// pop side
	// ------------------------------
	// words already owed to pipe-out that its count has not seen yet
	assign committed = SW'(out_count) + SW'(in_flight) + SW'(eng_q_valid);
	// one more pop must not bring pipe-out up to depth
	assign has_room  = (committed < SW'(DEPTH - 1));

	// host stream only while the engine has not claimed the port
	assign in_pop = enable && !eng_writes_en && !in_empty && has_room;

	always_ff @(posedge okClk) begin
		if (reset) begin
			in_flight <= '0;
		end else begin
			case ({in_pop, in_valid})
				2'b10:   in_flight <= in_flight + 1'b1;
				2'b01:   in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight;
			endcase
		end
	end

	// ------------------------------
	// engine side
	// ------------------------------
	// one stage of delay lets a host word popped just before the claim go out first
	always_ff @(posedge okClk) begin
		if (reset) begin
			eng_q_valid <= 1'b0;
		end else begin
			eng_q_valid <= eng_writes_en && eng_valid;
		end
	end

	always_ff @(posedge okClk) begin
		if (eng_writes_en && eng_valid) begin
			eng_q <= eng_data;
		end
	end

	// ------------------------------
	// push into pipe-out
	// ------------------------------
	// a host word and an engine word never arrive on the same cycle
	assign out_push = in_valid || eng_q_valid;
	assign out_data = in_valid ? in_data : eng_q;

endmodule

// File: pipe_top.sv
`timescale 1ns/10ps

module pipe_top #(
	parameter int DEPTH      = buffer_pkg::DEFAULT_DEPTH,
	parameter int BLOCK_SIZE = buffer_pkg::DEFAULT_BLOCK_SIZE,
	parameter int HEADROOM   = buffer_pkg::DEFAULT_HEADROOM
) (
	input  logic                              okClk,
	input  logic                              reset,
	input  logic [31:0]                       ctrl,
	input  logic                              pi_write,
	input  buffer_pkg::host_word_t            pi_data,
	output logic                              pi_ready,
	input  logic                              po_read,
	output buffer_pkg::host_word_t            po_data,
	output logic                              po_valid,
	output logic                              po_ready,
	input  logic                              eng_writes_en,
	input  buffer_pkg::host_word_t            eng_data,
	input  logic                              eng_valid,
	output logic [host_ctrl_pkg::LED_W-1:0]   led
);

	localparam int CW = buffer_pkg::count_w(DEPTH);

	logic                   fifo_flush;
	logic                   pipe_write_en;
	logic                   pipe_read_en;
	logic                   in_pop;
	buffer_pkg::host_word_t in_data;
	logic                   in_valid;
	logic                   in_empty;
	logic                   in_full;
	logic                   out_push;
	buffer_pkg::host_word_t out_data;
	logic [CW-1:0]          out_count;
	logic                   out_empty;
	logic                   out_full;
	logic [host_ctrl_pkg::LED_W-1:0] status;

	// ------------------------------
	// control word
	// ------------------------------
	assign fifo_flush    = ctrl[host_ctrl_pkg::CTRL_FIFO_RESET];
	assign pipe_write_en = ctrl[host_ctrl_pkg::CTRL_PIPE_WRITE];
	// read lamp also lights for an engine op request
	assign pipe_read_en  = ctrl[host_ctrl_pkg::CTRL_PIPE_READ] | ctrl[host_ctrl_pkg::CTRL_OP_EN];

	pipe_in_buffer #(
		.DEPTH      (DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.HEADROOM   (HEADROOM)
	) i_pipe_in (
		.okClk      (okClk),
		.reset      (reset),
		.flush      (fifo_flush),
		.write      (pi_write),    // host pipe-in strobe
		.data       (pi_data),
		.pop        (in_pop),
		.pop_data   (in_data),
		.pop_valid  (in_valid),
		.empty      (in_empty),
		.full       (in_full),
		.ready      (pi_ready)
	);

	pipe_out_buffer #(
		.DEPTH      (DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE)
	) i_pipe_out (
		.okClk      (okClk),
		.reset      (reset),
		.flush      (fifo_flush),
		.push       (out_push),
		.push_data  (out_data),
		.read       (po_read),     // host pipe-out strobe
		.read_data  (po_data),
		.read_valid (po_valid),
		.count      (out_count),
		.empty      (out_empty),
		.full       (out_full),
		.ready      (po_ready)
	);

	// mover drops its in-flight tally together with the buffers
	port0_mover #(
		.DEPTH         (DEPTH)
	) i_mover (
		.okClk         (okClk),
		.reset         (reset | fifo_flush),
		.enable        (pipe_write_en),
		.eng_writes_en (eng_writes_en),
		.eng_data      (eng_data),
		.eng_valid     (eng_valid),
		.in_empty      (in_empty),
		.in_data       (in_data),
		.in_valid      (in_valid),
		.in_pop        (in_pop),
		.out_count     (out_count),
		.out_push      (out_push),
		.out_data      (out_data)
	);

	// ------------------------------
	// status leds, lit when low
	// ------------------------------
	always_comb begin
		status = '0;
		status[host_ctrl_pkg::LED_PI_FULL]  = in_full;
		status[host_ctrl_pkg::LED_PI_EMPTY] = in_empty;
		status[host_ctrl_pkg::LED_PO_FULL]  = out_full;
		status[host_ctrl_pkg::LED_PO_EMPTY] = out_empty;
		status[host_ctrl_pkg::LED_WRITE_EN] = pipe_write_en;
		status[host_ctrl_pkg::LED_READ_EN]  = pipe_read_en;
	end

	assign led = ~status;

endmodule

// File: tb_pipe_top.sv
`timescale 1ns/10ps

module tb_pipe_top;

	localparam int DEPTH      = 64;
	localparam int BLOCK_SIZE = 16;
	localparam int HEADROOM   = 4;
	localparam int N_TESTS    = 5;
	localparam int PI_LIMIT   = DEPTH - HEADROOM - BLOCK_SIZE;  // highest count with pi_ready set
	localparam int SRC_HOST   = 0;
	localparam int SRC_ENGINE = 1;
	localparam int DRAIN_MAX  = 200;  // cycles allowed for the mover to empty pipe-in

	localparam logic [31:0] C_READ  = 32'd1 << host_ctrl_pkg::CTRL_PIPE_READ;
	localparam logic [31:0] C_WRITE = 32'd1 << host_ctrl_pkg::CTRL_PIPE_WRITE;
	localparam logic [31:0] C_FLUSH = 32'd1 << host_ctrl_pkg::CTRL_FIFO_RESET;
	localparam logic [31:0] C_OP    = 32'd1 << host_ctrl_pkg::CTRL_OP_EN;

	logic                            okClk;
	logic                            reset;
	logic [31:0]                     ctrl;
	logic                            pi_write;
	buffer_pkg::host_word_t          pi_data;
	logic                            pi_ready;
	logic                            po_read;
	buffer_pkg::host_word_t          po_data;
	logic                            po_valid;
	logic                            po_ready;
	logic                            eng_writes_en;
	buffer_pkg::host_word_t          eng_data;
	logic                            eng_valid;
	logic [host_ctrl_pkg::LED_W-1:0] led;

	// ------------------------------
	// stimulus table
	// ------------------------------
	string                           t_name   [N_TESTS];
	int                              t_src    [N_TESTS];
	int                              t_hold   [N_TESTS];  // host words parked before the claim
	int                              t_count  [N_TESTS];
	logic [31:0]                     t_ctrl   [N_TESTS];
	logic                            t_pi_rdy [N_TESTS];
	logic                            t_po_rdy [N_TESTS];
	logic [host_ctrl_pkg::LED_W-1:0] t_led    [N_TESTS];

	buffer_pkg::host_word_t exp_q[$];   // words owed to pipe-out, in order
	buffer_pkg::host_word_t held_q[$];  // words sitting in pipe-in with the mover off
	logic [31:0]            rng;
	int                     pi_level;   // pipe-in count while the mover is off
	int                     n_mismatch;
	int                     n_other;
	int                     total_words;
	bit                     table_loaded;

	initial okClk = 1'b0;
	always #4 okClk = ~okClk;

	pipe_top #(
		.DEPTH         (DEPTH),
		.BLOCK_SIZE    (BLOCK_SIZE),
		.HEADROOM      (HEADROOM)
	) i_dut (
		.okClk         (okClk),
		.reset         (reset),
		.ctrl          (ctrl),
		.pi_write      (pi_write),
		.pi_data       (pi_data),
		.pi_ready      (pi_ready),
		.po_read       (po_read),
		.po_data       (po_data),
		.po_valid      (po_valid),
		.po_ready      (po_ready),
		.eng_writes_en (eng_writes_en),
		.eng_data      (eng_data),
		.eng_valid     (eng_valid),
		.led           (led)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// a lamp is lit when its line is low
	function automatic logic [host_ctrl_pkg::LED_W-1:0] led_pattern(input logic pi_full,
			input logic pi_empty, input logic po_full, input logic po_empty,
			input logic wr_en, input logic rd_en);
		logic [host_ctrl_pkg::LED_W-1:0] s;
		s = '0;
		s[host_ctrl_pkg::LED_PI_FULL]  = pi_full;
		s[host_ctrl_pkg::LED_PI_EMPTY] = pi_empty;
		s[host_ctrl_pkg::LED_PO_FULL]  = po_full;
		s[host_ctrl_pkg::LED_PO_EMPTY] = po_empty;
		s[host_ctrl_pkg::LED_WRITE_EN] = wr_en;
		s[host_ctrl_pkg::LED_READ_EN]  = rd_en;
		return ~s;
	endfunction

	task automatic set_entry(input int idx, input string name, input int src, input int hold,
			input int count, input logic [31:0] c, input logic pi_r, input logic po_r,
			input logic [host_ctrl_pkg::LED_W-1:0] l);
		t_name[idx]   = name;
		t_src[idx]    = src;
		t_hold[idx]   = hold;
		t_count[idx]  = count;
		t_ctrl[idx]   = c;
		t_pi_rdy[idx] = pi_r;
		t_po_rdy[idx] = po_r;
		t_led[idx]    = l;
	endtask

	task automatic check_value(input string name, input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			n_mismatch++;
			$display("mismatch %s %s: expected %h, actual %h", name, what, exp, act);
		end
	endtask

	task automatic write_host(input string name, input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge okClk);
			rng      = xorshift32(rng);
			pi_write = 1'b1;
			pi_data  = rng;
			if (ctrl[host_ctrl_pkg::CTRL_PIPE_WRITE]) begin
				exp_q.push_back(rng);
			end else begin
				held_q.push_back(rng);
				pi_level++;
				if (pi_level == PI_LIMIT || pi_level == PI_LIMIT + 1) begin  // count update, then flag update
					@(negedge okClk);
					pi_write = 1'b0;
					@(negedge okClk);
					check_value(name, "pi_ready near limit", pi_level <= PI_LIMIT, pi_ready);
					check_value(name, "led pi empty", 32'd1, led[host_ctrl_pkg::LED_PI_EMPTY]);
				end
			end
		end
		@(negedge okClk);
		pi_write = 1'b0;
	endtask

	task automatic send_engine(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge okClk);
			rng       = xorshift32(rng);
			eng_valid = 1'b1;
			eng_data  = rng;
			exp_q.push_back(rng);
		end
		@(negedge okClk);
		eng_valid = 1'b0;
	endtask

	task automatic release_held();
		while (held_q.size() > 0) begin
			exp_q.push_back(held_q.pop_front());
		end
	endtask

	// let the mover finish and the flags catch up
	task automatic settle(input string name);
		int waited;
		waited = 0;
		if (ctrl[host_ctrl_pkg::CTRL_PIPE_WRITE] && !eng_writes_en) begin
			while (led[host_ctrl_pkg::LED_PI_EMPTY] !== 1'b0 && waited < DRAIN_MAX) begin
				@(negedge okClk);
				waited++;
			end
			assert (waited < DRAIN_MAX) else begin
				n_other++;
				$display("%s: the mover did not empty pipe-in in time", name);
			end
			pi_level = 0;
		end
		repeat (3) begin
			@(negedge okClk);
			assert (po_valid === 1'b0) else begin
				n_other++;
				$display("%s: po_valid pulsed without a read", name);
			end
		end
	endtask

	task automatic read_word(input string name, input logic [31:0] exp);
		@(negedge okClk);
		po_read = 1'b1;
		@(negedge okClk);
		po_read = 1'b0;  // data comes back one cycle after the read
		assert (po_valid === 1'b1) else begin
			n_other++;
			$display("%s: a read of a waiting word gave no po_valid", name);
		end
		check_value(name, "po_data", exp, po_data);
	endtask

	task automatic drain(input string name);
		while (exp_q.size() > 0) begin
			read_word(name, exp_q.pop_front());
		end
	endtask

	task automatic empty_read(input string name);
		@(negedge okClk);
		po_read = 1'b1;
		@(negedge okClk);
		po_read = 1'b0;
		assert (po_valid === 1'b0) else begin
			n_other++;
			$display("%s: a read of an empty pipe-out gave po_valid", name);
		end
	endtask

	task automatic apply_entry(input int i);
		string name;
		name = t_name[i];
		if (t_ctrl[i] & C_FLUSH) begin
			// move a few parked words on so both buffers hold data before the flush
			@(negedge okClk);
			ctrl = C_WRITE;
			repeat (t_count[i]) @(negedge okClk);
			ctrl = t_ctrl[i];
			@(negedge okClk);
			ctrl = '0;
			exp_q.delete();
			held_q.delete();
			pi_level = 0;
		end else if (t_src[i] == SRC_ENGINE) begin
			@(negedge okClk);
			ctrl = '0;  // mover off so the host words stay parked
			write_host(name, t_hold[i]);
			@(negedge okClk);
			ctrl          = t_ctrl[i];
			eng_writes_en = 1'b1;
			send_engine(t_count[i]);
		end else begin
			@(negedge okClk);
			ctrl = t_ctrl[i];
			if (ctrl[host_ctrl_pkg::CTRL_PIPE_WRITE]) begin
				release_held();
			end
			write_host(name, t_count[i]);
		end
		settle(name);
		check_value(name, "pi_ready", t_pi_rdy[i], pi_ready);
		check_value(name, "po_ready", t_po_rdy[i], po_ready);
		check_value(name, "led", t_led[i], led);
		drain(name);
		if (eng_writes_en) begin
			@(negedge okClk);
			eng_writes_en = 1'b0;  // parked host words follow the engine stream
			release_held();
			settle(name);
			drain(name);
		end
		empty_read(name);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		reset         = 1'b1;
		ctrl          = '0;
		pi_write      = 1'b0;
		pi_data       = '0;
		po_read       = 1'b0;
		eng_writes_en = 1'b0;
		eng_data      = '0;
		eng_valid     = 1'b0;
		rng           = 32'd73544;
		pi_level      = 0;
		n_mismatch    = 0;
		n_other       = 0;
		set_entry(0, "reset_state", SRC_HOST, 0, 0, 32'h0, 1'b1, 1'b0,
			led_pattern(0, 1, 0, 1, 0, 0));
		set_entry(1, "host_loopback", SRC_HOST, 0, 40, C_WRITE | C_READ, 1'b1, 1'b1,
			led_pattern(0, 1, 0, 0, 1, 1));
		set_entry(2, "engine_claim", SRC_ENGINE, 8, 12, C_WRITE, 1'b1, 1'b0,
			led_pattern(0, 0, 0, 0, 1, 0));
		set_entry(3, "throttle", SRC_HOST, 0, 50, C_OP, 1'b0, 1'b0,
			led_pattern(0, 0, 0, 1, 0, 1));
		set_entry(4, "flush", SRC_HOST, 0, 4, C_FLUSH, 1'b1, 1'b0,
			led_pattern(0, 1, 0, 1, 0, 0));
		total_words = 0;
		for (int i = 0; i < N_TESTS; i++) begin
			total_words += t_hold[i] + t_count[i];
		end
		table_loaded = 1'b1;
		repeat (10) @(negedge okClk);
		reset = 1'b0;
		for (int i = 0; i < N_TESTS; i++) begin
			apply_entry(i);
		end
		$display("errors: %0d mismatch, %0d other", n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (table_loaded);
		repeat (total_words * 20 + 1000) @(posedge okClk);
		$display("timeout: the run did not finish within %0d cycles", total_words * 20 + 1000);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: vlog.f
buffer_pkg.sv
host_ctrl_pkg.sv
pipe_in_buffer.sv
pipe_out_buffer.sv
port0_mover.sv
pipe_top.sv
tb_pipe_top.sv

// File: Bender.yml
package:
  name: pipe_top

sources:
  # packages first, then the modules that use them
  - files:
      - buffer_pkg.sv
      - host_ctrl_pkg.sv
      - pipe_in_buffer.sv
      - pipe_out_buffer.sv
      - port0_mover.sv
      - pipe_top.sv

  # testbench
  - target: test
    files:
      - tb_pipe_top.sv
